// File: hw/ppu_bus_pkg.sv
/*
 * PPU CPU bus definitions
 * Data byte type and the register access opcodes seen by the units
 */
`default_nettype none

package ppu_bus_pkg;

    localparam int DATA_W = 8;

    typedef logic [DATA_W-1:0] data_t;

    // Register accesses presented on the bus
    typedef enum logic [4:0] {
        B_NOP,
        // Writes
        B_VMAIN,
        B_VMADDL,
        B_VMADDH,
        B_VMDATAL,
        B_VMDATAH,
        B_CGADD,
        B_CGDATA,
        B_M7A,
        B_M7B,
        B_SLHV,
        // Reads
        B_RDVRAML,
        B_RDVRAMH,
        B_RDCGRAM,
        B_MPYL,
        B_MPYM,
        B_MPYH,
        B_OPHCT,
        B_OPVCT,
        B_STAT78
    } b_op_t;

endpackage

`default_nettype wire

// File: hw/ppu_cgram_port.sv
/*
 * PPU CGRAM port
 * 256-entry palette written and read a byte at a time
 */
`timescale 1ns/1ps
`default_nettype none

module ppu_cgram_port (
    input logic clk,
    input logic reset,
    ppu_reg_if.unit bus
);

    localparam int CGRAM_ENTRIES = 256;

    ppu_mem_pkg::color_t cgram [CGRAM_ENTRIES];

    ppu_mem_pkg::cgram_addr_t cg_addr;
    logic cg_tgl;
    ppu_mem_pkg::color_t cg_entry;

    // Address and byte toggle count together
    always_ff @(posedge clk) begin
        if (reset) begin
            {cg_addr, cg_tgl} <= '0;
        end else if (bus.en) begin
            case (bus.op)
                ppu_bus_pkg::B_CGADD:   {cg_addr, cg_tgl} <= {bus.wdata, 1'b0};
                ppu_bus_pkg::B_CGDATA,
                ppu_bus_pkg::B_RDCGRAM: {cg_addr, cg_tgl} <= {cg_addr, cg_tgl} + 9'd1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (bus.en && (bus.op == ppu_bus_pkg::B_CGDATA)) begin
            if (cg_tgl) begin
                cgram[cg_addr][14:8] <= bus.wdata[6:0];
            end else begin
                cgram[cg_addr][7:0] <= bus.wdata;
            end
        end
    end

    assign cg_entry = cgram[cg_addr];

    always_comb begin
        if (bus.op == ppu_bus_pkg::B_RDCGRAM) begin
            bus.rdata = cg_tgl ? {1'b0, cg_entry[14:8]} : cg_entry[7:0];
        end else begin
            bus.rdata = '0;
        end
    end

endmodule

`default_nettype wire

// File: hw/ppu_mem_pkg.sv
/*
 * PPU memory definitions
 * VRAM and CGRAM address/data types, remap modes and increment steps
 */
`default_nettype none

package ppu_mem_pkg;

    typedef logic [14:0] vram_addr_t;
    typedef logic [15:0] vram_word_t;

    typedef logic [7:0] cgram_addr_t;
    typedef logic [14:0] color_t;

    // Low N address bits rotated left by three
    typedef enum logic [1:0] {
        REMAP_NONE = 2'd0,
        REMAP_8    = 2'd1,
        REMAP_9    = 2'd2,
        REMAP_10   = 2'd3
    } remap_t;

    typedef enum logic [1:0] {
        STEP_1     = 2'd0,
        STEP_32    = 2'd1,
        STEP_128   = 2'd2,
        STEP_128_B = 2'd3
    } step_t;

endpackage

`default_nettype wire

// File: hw/ppu_reg_if.sv
/*
 * PPU register access interface
 * One CPU register access fanned from the top into a unit
 */
`timescale 1ns/1ps
`default_nettype none

interface ppu_reg_if;

    logic en;
    ppu_bus_pkg::b_op_t op;
    ppu_bus_pkg::data_t wdata;
    ppu_bus_pkg::data_t rdata;

    modport host (output en, output op, output wdata, input rdata);
    modport unit (input en, input op, input wdata, output rdata);

endinterface

`default_nettype wire

// File: hw/ppu_regs.sv
/*
 * PPU misc registers
 * Signed multiplier, H/V counter latch, status and the merged read byte
 */
`timescale 1ns/1ps
`default_nettype none

module ppu_regs (
    input logic clk,
    input logic reset,
    ppu_reg_if.unit bus,
    input ppu_bus_pkg::data_t vram_rdata,
    input ppu_bus_pkg::data_t cgram_rdata,
    input logic [8:0] h_ctr,
    input logic [8:0] v_ctr
);

    localparam int CTR_W = 9;
    localparam logic [3:0] PPU_VERSION = 4'h2;

    ppu_bus_pkg::data_t m7_old;
    logic signed [15:0] m7_a;
    logic signed [7:0] m7_b;
    logic signed [23:0] mpy;

    logic [CTR_W-1:0] h_latch;
    logic [CTR_W-1:0] v_latch;
    logic hv_flag;
    logic h_tgl;
    logic v_tgl;
    ppu_bus_pkg::data_t own_rdata;

    // ---- Multiplier --------

    always_ff @(posedge clk) begin
        if (bus.en && ((bus.op == ppu_bus_pkg::B_M7A) || (bus.op == ppu_bus_pkg::B_M7B))) begin
            m7_old <= bus.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            m7_a <= '0;
            m7_b <= '0;
        end else if (bus.en && (bus.op == ppu_bus_pkg::B_M7A)) begin
            m7_a <= {bus.wdata, m7_old};
        end else if (bus.en && (bus.op == ppu_bus_pkg::B_M7B)) begin
            m7_b <= bus.wdata;
        end
    end

    assign mpy = m7_a * m7_b;

    // ---- H/V latch --------

    always_ff @(posedge clk) begin
        if (reset) begin
            h_latch <= '0;
            v_latch <= '0;
            hv_flag <= 1'b0;
            h_tgl <= 1'b0;
            v_tgl <= 1'b0;
        end else if (bus.en) begin
            case (bus.op)
                ppu_bus_pkg::B_SLHV: begin
                    h_latch <= h_ctr;
                    v_latch <= v_ctr;
                    hv_flag <= 1'b1;
                end
                ppu_bus_pkg::B_OPHCT: h_tgl <= ~h_tgl;
                ppu_bus_pkg::B_OPVCT: v_tgl <= ~v_tgl;
                ppu_bus_pkg::B_STAT78: begin
                    hv_flag <= 1'b0;
                    h_tgl <= 1'b0;
                    v_tgl <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    // ---- Read byte --------

    always_comb begin
        case (bus.op)
            ppu_bus_pkg::B_MPYL:   own_rdata = mpy[7:0];
            ppu_bus_pkg::B_MPYM:   own_rdata = mpy[15:8];
            ppu_bus_pkg::B_MPYH:   own_rdata = mpy[23:16];
            ppu_bus_pkg::B_OPHCT:  own_rdata = h_tgl ? {7'h0, h_latch[8]} : h_latch[7:0];
            ppu_bus_pkg::B_OPVCT:  own_rdata = v_tgl ? {7'h0, v_latch[8]} : v_latch[7:0];
            ppu_bus_pkg::B_STAT78: own_rdata = {1'b0, hv_flag, 2'b00, PPU_VERSION};
            default:               own_rdata = '0;
        endcase
    end

    // Other units already return zero outside their own opcodes
    assign bus.rdata = own_rdata | vram_rdata | cgram_rdata;

endmodule

`default_nettype wire

// File: hw/ppu_timing.sv
/*
 * PPU raster timing
 * Dot counter per line and line counter per frame
 */
`timescale 1ns/1ps
`default_nettype none

module ppu_timing #(
    parameter int H_TOTAL = 341,
    parameter int V_TOTAL = 262
) (
    input logic clk,
    input logic reset,
    output logic [8:0] h_ctr,
    output logic [8:0] v_ctr
);

    localparam int CTR_W = 9;

    localparam logic [CTR_W-1:0] H_LAST = CTR_W'(H_TOTAL - 1);
    localparam logic [CTR_W-1:0] V_LAST = CTR_W'(V_TOTAL - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            h_ctr <= '0;
            v_ctr <= '0;
        end else if (h_ctr == H_LAST) begin
            h_ctr <= '0;
            // Next line wraps at end of frame
            if (v_ctr == V_LAST) begin
                v_ctr <= '0;
            end else begin
                v_ctr <= v_ctr + 1'b1;
            end
        end else begin
            h_ctr <= h_ctr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/ppu_top.sv
/*
 * PPU register side top level
 * Fans the CPU bus into the VRAM, CGRAM and register units
 */
`timescale 1ns/1ps
`default_nettype none

module ppu_top #(
    parameter int H_TOTAL = 341,
    parameter int V_TOTAL = 262
) (
    input logic clk,
    input logic reset,
    input logic cpu_en,
    input ppu_bus_pkg::b_op_t b_op,
    input ppu_bus_pkg::data_t wdata,
    output ppu_bus_pkg::data_t rdata,
    output logic [8:0] h_ctr,
    output logic [8:0] v_ctr
);

    localparam int CTR_W = 9;

    logic [CTR_W-1:0] h_cnt;
    logic [CTR_W-1:0] v_cnt;

    ppu_reg_if vram_bus ();
    ppu_reg_if cgram_bus ();
    ppu_reg_if regs_bus ();

    assign vram_bus.en = cpu_en;
    assign vram_bus.op = b_op;
    assign vram_bus.wdata = wdata;
    assign cgram_bus.en = cpu_en;
    assign cgram_bus.op = b_op;
    assign cgram_bus.wdata = wdata;
    assign regs_bus.en = cpu_en;
    assign regs_bus.op = b_op;
    assign regs_bus.wdata = wdata;

    ppu_timing #(
        .H_TOTAL(H_TOTAL),
        .V_TOTAL(V_TOTAL)
    ) ppu_timing_i (
        .clk(clk),
        .reset(reset),
        .h_ctr(h_cnt),
        .v_ctr(v_cnt)
    );

    ppu_vram_port ppu_vram_port_i (
        .clk(clk),
        .reset(reset),
        .bus(vram_bus.unit)
    );

    ppu_cgram_port ppu_cgram_port_i (
        .clk(clk),
        .reset(reset),
        .bus(cgram_bus.unit)
    );

    ppu_regs ppu_regs_i (
        .clk(clk),
        .reset(reset),
        .bus(regs_bus.unit),
        .vram_rdata(vram_bus.rdata),
        .cgram_rdata(cgram_bus.rdata),
        .h_ctr(h_cnt),
        .v_ctr(v_cnt)
    );

    assign rdata = regs_bus.rdata;
    assign h_ctr = h_cnt;
    assign v_ctr = v_cnt;

endmodule

`default_nettype wire

// File: hw/ppu_vram_port.sv
/*
 * PPU VRAM port
 * Word storage in two byte lanes, CPU address register with remap
 * and step increment, and the read prefetch latch
 */
`timescale 1ns/1ps
`default_nettype none

module ppu_vram_port (
    input logic clk,
    input logic reset,
    ppu_reg_if.unit bus
);

    localparam int VRAM_WORDS = 32768;

    ppu_bus_pkg::data_t vram_l [VRAM_WORDS];
    ppu_bus_pkg::data_t vram_h [VRAM_WORDS];

    ppu_mem_pkg::remap_t remap;
    ppu_mem_pkg::step_t step;
    logic inc_high;

    ppu_mem_pkg::vram_addr_t addr_reg;
    ppu_mem_pkg::vram_addr_t ram_addr;
    ppu_mem_pkg::vram_addr_t step_amt;
    ppu_mem_pkg::vram_word_t prefetch;
    logic prefetch_pend;
    logic inc_hit;
    logic is_read;

    // ------------------------------
    // Address path
    // ------------------------------

    always_comb begin
        case (remap)
            ppu_mem_pkg::REMAP_8:  ram_addr = {addr_reg[14:8], addr_reg[4:0], addr_reg[7:5]};
            ppu_mem_pkg::REMAP_9:  ram_addr = {addr_reg[14:9], addr_reg[5:0], addr_reg[8:6]};
            ppu_mem_pkg::REMAP_10: ram_addr = {addr_reg[14:10], addr_reg[6:0], addr_reg[9:7]};
            default:               ram_addr = addr_reg;
        endcase
    end

    always_comb begin
        case (step)
            ppu_mem_pkg::STEP_1:  step_amt = 15'd1;
            ppu_mem_pkg::STEP_32: step_amt = 15'd32;
            default:              step_amt = 15'd128;
        endcase
    end

    assign is_read = (bus.op == ppu_bus_pkg::B_RDVRAML) || (bus.op == ppu_bus_pkg::B_RDVRAMH);

    // Access on the selected byte advances the address
    always_comb begin
        if (inc_high) begin
            inc_hit = bus.en && ((bus.op == ppu_bus_pkg::B_VMDATAH)
                || (bus.op == ppu_bus_pkg::B_RDVRAMH));
        end else begin
            inc_hit = bus.en && ((bus.op == ppu_bus_pkg::B_VMDATAL)
                || (bus.op == ppu_bus_pkg::B_RDVRAML));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            remap <= ppu_mem_pkg::REMAP_NONE;
            step <= ppu_mem_pkg::STEP_1;
            inc_high <= 1'b0;
            addr_reg <= '0;
        end else if (bus.en) begin
            case (bus.op)
                ppu_bus_pkg::B_VMAIN: begin
                    inc_high <= bus.wdata[7];
                    remap <= ppu_mem_pkg::remap_t'(bus.wdata[3:2]);
                    step <= ppu_mem_pkg::step_t'(bus.wdata[1:0]);
                end
                ppu_bus_pkg::B_VMADDL: addr_reg[7:0] <= bus.wdata;
                ppu_bus_pkg::B_VMADDH: addr_reg[14:8] <= bus.wdata[6:0];
                default: begin
                    if (inc_hit) begin
                        addr_reg <= addr_reg + step_amt;
                    end
                end
            endcase
        end
    end

    // ------------------------------
    // Storage and prefetch
    // ------------------------------

    always_ff @(posedge clk) begin
        if (bus.en && (bus.op == ppu_bus_pkg::B_VMDATAL)) begin
            vram_l[ram_addr] <= bus.wdata;
        end
        if (bus.en && (bus.op == ppu_bus_pkg::B_VMDATAH)) begin
            vram_h[ram_addr] <= bus.wdata;
        end
    end

    // Reload one cycle after the address has moved
    always_ff @(posedge clk) begin
        if (reset) begin
            prefetch_pend <= 1'b0;
            prefetch <= '0;
        end else begin
            prefetch_pend <= bus.en && ((bus.op == ppu_bus_pkg::B_VMADDL)
                || (bus.op == ppu_bus_pkg::B_VMADDH) || (inc_hit && is_read));
            if (prefetch_pend) begin
                prefetch <= {vram_h[ram_addr], vram_l[ram_addr]};
            end
        end
    end

    always_comb begin
        case (bus.op)
            ppu_bus_pkg::B_RDVRAML: bus.rdata = prefetch[7:0];
            ppu_bus_pkg::B_RDVRAMH: bus.rdata = prefetch[15:8];
            default:                bus.rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the PPU register testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing -Wno-fatal --top-module ppu_tb -f vlog.f -o ppu_sim \
    > build.log 2>&1 \
    && ./obj_dir/ppu_sim > sim.log 2>&1 \
    || { cat build.log; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verif/ppu_tb.sv
/*
 * PPU register side testbench
 * Table of bus accesses with expected read bytes, applied in a loop
 */
`timescale 1ns/1ps
`default_nettype none

module ppu_tb;

    localparam int H_TOTAL = 20;
    localparam int V_TOTAL = 8;

    // Where a checked read takes its expected byte from
    typedef enum logic [2:0] {
        EXP_CONST,
        EXP_H_LO,
        EXP_H_HI,
        EXP_V_LO,
        EXP_V_HI
    } exp_src_t;

    typedef struct packed {
        ppu_bus_pkg::b_op_t op;
        ppu_bus_pkg::data_t wdata;
        logic chk;
        ppu_bus_pkg::data_t exp;
        exp_src_t src;
    } row_t;

    logic clk;
    logic reset;
    logic cpu_en;
    ppu_bus_pkg::b_op_t b_op;
    ppu_bus_pkg::data_t wdata;
    ppu_bus_pkg::data_t rdata;
    logic [8:0] h_ctr;
    logic [8:0] v_ctr;

    row_t rows[$];
    row_t cur;
    ppu_bus_pkg::b_op_t cur_op;
    ppu_bus_pkg::data_t expected;
    ppu_mem_pkg::vram_word_t vram_words [3];
    ppu_mem_pkg::vram_addr_t remap_addr;
    ppu_mem_pkg::color_t color;
    logic signed [15:0] mpy_a;
    logic signed [7:0] mpy_b;
    logic signed [23:0] mpy_p;
    logic [8:0] h_sample;
    logic [8:0] v_sample;
    logic [8:0] exp_h;
    logic [8:0] exp_v;
    integer seed;
    int dots;
    int errors;
    int checks;
    int cycles;
    int cycle_limit;
    int i;

    ppu_top #(
        .H_TOTAL(H_TOTAL),
        .V_TOTAL(V_TOTAL)
    ) ppu_top_i (
        .clk(clk),
        .reset(reset),
        .cpu_en(cpu_en),
        .b_op(b_op),
        .wdata(wdata),
        .rdata(rdata),
        .h_ctr(h_ctr),
        .v_ctr(v_ctr)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: table not finished after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // Dots since reset release
    always @(posedge clk) begin
        if (reset) begin
            dots <= 0;
        end else begin
            dots <= dots + 1;
        end
    end

    task automatic add_row(input ppu_bus_pkg::b_op_t op, input ppu_bus_pkg::data_t wd,
                           input logic chk, input ppu_bus_pkg::data_t exp, input exp_src_t src);
        row_t r;
        r.op = op;
        r.wdata = wd;
        r.chk = chk;
        r.exp = exp;
        r.src = src;
        rows.push_back(r);
    endtask

    // Low n address bits rotated left by three
    function automatic ppu_mem_pkg::vram_addr_t rotate_low(input ppu_mem_pkg::vram_addr_t a,
                                                           input int n);
        ppu_mem_pkg::vram_addr_t r;
        int k;
        r = a;
        for (k = 0; k < n; k++) begin
            r[(k + 3) % n] = a[k];
        end
        return r;
    endfunction

    task automatic build_table();
        int w;
        // ------------------------------
        // VRAM step 1, increment on high byte
        // ------------------------------
        vram_words[0] = 16'h1234;
        vram_words[1] = 16'hABCD;
        vram_words[2] = 16'h5A0F;
        add_row(ppu_bus_pkg::B_VMAIN, 8'h80, 1'b0, 8'h00, EXP_CONST);
        add_row(ppu_bus_pkg::B_VMADDL, 8'h10, 1'b0, 8'h00, EXP_CONST);
        add_row(ppu_bus_pkg::B_VMADDH, 8'h00, 1'b0, 8'h00, EXP_CONST);
        for (w = 0; w < 3; w++) begin
            add_row(ppu_bus_pkg::B_VMDATAL, vram_words[w][7:0], 1'b0, 8'h00, EXP_CONST);
            add_row(ppu_bus_pkg::B_VMDATAH, vram_words[w][15:8], 1'b0, 8'h00, EXP_CONST);
        end
        add_row(ppu_bus_pkg::B_VMADDL, 8'h10, 1'b0, 8'h00, EXP_CONST);
        add_row(ppu_bus_pkg::B_VMADDH, 8'h00, 1'b0, 8'h00, EXP_CONST);
        for (w = 0; w < 3; w++) begin
            add_row(ppu_bus_pkg::B_RDVRAML, 8'h00, 1'b1, vram_words[w][7:0], EXP_CONST);
            add_row(ppu_bus_pkg::B_RDVRAMH, 8'h00, 1'b1, vram_words[w][15:8], EXP_CONST);
        end
        // ------------------------------
        // VRAM step 32 and remap
        // ------------------------------
        add_row(ppu_bus_pkg::B_VMAIN, 8'h01, 1'b0, 8'h00, EXP_CONST);
        add_row(ppu_bus_pkg::B_VMADDL, 8'h00, 1'b0, 8'h00, EXP_CONST);
        add_row(ppu_bus_pkg::B_VMADDH, 8'h02, 1'b0, 8'h00, EXP_CONST);
        add_row(ppu_bus_pkg::B_VMDATAL, 8'h3E, 1'b0, 8'h00, EXP_CONST);
        add_row(ppu_bus_pkg::B_VMDATAL, 8'hC1, 1'b0, 8'h00, EXP_CONST);
        add_row(ppu_bus_pkg::B_VMAIN, 8'h04, 1'b0, 8'h00, EXP_CONST);
        add_row(ppu_bus_pkg::B_VMADDL, 8'h25, 1'b0, 8'h00, EXP_CONST);
        add_row(ppu_bus_pkg::B_VMADDH, 8'h03, 1'b0, 8'h00, EXP_CONST);
        add_row(ppu_bus_pkg::B_VMDATAL, 8'h77, 1'b0, 8'h00, EXP_CONST);
        remap_addr = rotate_low(15'h0325, 8);
        add_row(ppu_bus_pkg::B_VMAIN, 8'h01, 1'b0, 8'h00, EXP_CONST);
        add_row(ppu_bus_pkg::B_VMADDL, 8'h00, 1'b0, 8'h00, EXP_CONST);
        add_row(ppu_bus_pkg::B_VMADDH, 8'h02, 1'b0, 8'h00, EXP_CONST);
        add_row(ppu_bus_pkg::B_RDVRAML, 8'h00, 1'b1, 8'h3E, EXP_CONST);
        add_row(ppu_bus_pkg::B_RDVRAML, 8'h00, 1'b1, 8'hC1, EXP_CONST);
        add_row(ppu_bus_pkg::B_VMADDL, remap_addr[7:0], 1'b0, 8'h00, EXP_CONST);
        add_row(ppu_bus_pkg::B_VMADDH, {1'b0, remap_addr[14:8]}, 1'b0, 8'h00, EXP_CONST);
        add_row(ppu_bus_pkg::B_RDVRAML, 8'h00, 1'b1, 8'h77, EXP_CONST);
        // CGRAM high byte keeps 7 bits
        color = {7'h15, 8'h3C};
        add_row(ppu_bus_pkg::B_CGADD, 8'h05, 1'b0, 8'h00, EXP_CONST);
        add_row(ppu_bus_pkg::B_CGDATA, color[7:0], 1'b0, 8'h00, EXP_CONST);
        add_row(ppu_bus_pkg::B_CGDATA, {1'b1, color[14:8]}, 1'b0, 8'h00, EXP_CONST);
        add_row(ppu_bus_pkg::B_CGADD, 8'h05, 1'b0, 8'h00, EXP_CONST);
        add_row(ppu_bus_pkg::B_RDCGRAM, 8'h00, 1'b1, color[7:0], EXP_CONST);
        add_row(ppu_bus_pkg::B_RDCGRAM, 8'h00, 1'b1, {1'b0, color[14:8]}, EXP_CONST);
        // Signed 16x8 multiply
        mpy_a = 16'($random(seed));
        mpy_b = 8'($random(seed));
        mpy_p = 24'(mpy_a) * 24'(mpy_b);
        add_row(ppu_bus_pkg::B_M7A, mpy_a[7:0], 1'b0, 8'h00, EXP_CONST);
        add_row(ppu_bus_pkg::B_M7A, mpy_a[15:8], 1'b0, 8'h00, EXP_CONST);
        add_row(ppu_bus_pkg::B_M7B, mpy_b, 1'b0, 8'h00, EXP_CONST);
        add_row(ppu_bus_pkg::B_MPYL, 8'h00, 1'b1, mpy_p[7:0], EXP_CONST);
        add_row(ppu_bus_pkg::B_MPYM, 8'h00, 1'b1, mpy_p[15:8], EXP_CONST);
        add_row(ppu_bus_pkg::B_MPYH, 8'h00, 1'b1, mpy_p[23:16], EXP_CONST);
        // H/V latch and status
        add_row(ppu_bus_pkg::B_SLHV, 8'h00, 1'b0, 8'h00, EXP_CONST);
        add_row(ppu_bus_pkg::B_OPHCT, 8'h00, 1'b1, 8'h00, EXP_H_LO);
        add_row(ppu_bus_pkg::B_OPHCT, 8'h00, 1'b1, 8'h00, EXP_H_HI);
        add_row(ppu_bus_pkg::B_OPVCT, 8'h00, 1'b1, 8'h00, EXP_V_LO);
        add_row(ppu_bus_pkg::B_OPVCT, 8'h00, 1'b1, 8'h00, EXP_V_HI);
        add_row(ppu_bus_pkg::B_STAT78, 8'h00, 1'b1, 8'h42, EXP_CONST);
        add_row(ppu_bus_pkg::B_STAT78, 8'h00, 1'b1, 8'h02, EXP_CONST);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        cpu_en = 1'b0;
        b_op = ppu_bus_pkg::B_NOP;
        wdata = '0;
        seed = 32'h9da72eb8;
        dots = 0;
        errors = 0;
        checks = 0;
        cycles = 0;
        h_sample = '0;
        v_sample = '0;
        build_table();
        cycle_limit = rows.size() * 3 + 40;

        repeat (10) @(posedge clk);
        reset <= 1'b0;

        for (i = 0; i < rows.size(); i++) begin
            cur = rows[i];
            cur_op = cur.op;
            @(posedge clk);
            cpu_en <= 1'b1;
            b_op <= cur_op;
            wdata <= cur.wdata;
            // Read byte and counters settle by mid-cycle
            @(negedge clk);
            exp_h = 9'(dots % H_TOTAL);
            exp_v = 9'((dots / H_TOTAL) % V_TOTAL);
            checks++;
            if (h_ctr !== exp_h || v_ctr !== exp_v) begin
                errors++;
                $display("CHECK FAILED at %0t: row %0d h/v %0d/%0d, expected %0d/%0d",
                         $time, i, h_ctr, v_ctr, exp_h, exp_v);
            end
            if (cur_op == ppu_bus_pkg::B_SLHV) begin
                h_sample = exp_h;
                v_sample = exp_v;
            end
            if (cur.chk) begin
                case (cur.src)
                    EXP_H_LO: expected = h_sample[7:0];
                    EXP_H_HI: expected = {7'h00, h_sample[8]};
                    EXP_V_LO: expected = v_sample[7:0];
                    EXP_V_HI: expected = {7'h00, v_sample[8]};
                    default:  expected = cur.exp;
                endcase
                checks++;
                if (rdata !== expected) begin
                    errors++;
                    $display("CHECK FAILED at %0t: row %0d %s read %02h, expected %02h",
                             $time, i, cur_op.name(), rdata, expected);
                end
            end
            @(posedge clk);
            cpu_en <= 1'b0;
            b_op <= ppu_bus_pkg::B_NOP;
            wdata <= '0;
            @(posedge clk);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
hw/ppu_bus_pkg.sv
hw/ppu_mem_pkg.sv
hw/ppu_reg_if.sv
hw/ppu_timing.sv
hw/ppu_vram_port.sv
hw/ppu_cgram_port.sv
hw/ppu_regs.sv
hw/ppu_top.sv
verif/ppu_tb.sv
